/* filelist.f */
common/hwpe_store_pkg.sv
design/store_ctrl.sv
hwpe_stream_split/hwpe_stream_split.sv
design/tcdm_store_port.sv
design/hwpe_store_top.sv
testbench/tcdm_mem_model.sv
testbench/tb_hwpe_store.sv

/* Makefile */
# Verilator build and run for the store engine testbench.

VERILATOR ?= verilator
TOP       ?= tb_hwpe_store
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code of the simulator.
run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_hwpe_store.sv */
// Store engine testbench: random commands and beats, scoreboard and protocol assertions.
`timescale 1ns/1ps

module tb_hwpe_store;
  import hwpe_store_pkg::*;

  localparam int unsigned NB_LANES   = 4;
  localparam int unsigned DATA_W     = 128;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned BEAT_BYTES = 16;
  localparam int unsigned SEED       = 7220;
  localparam int unsigned NB_CMDS    = 20;
  localparam int unsigned MAX_BEATS  = 12;
  localparam int unsigned MAX_DELAY  = 3;

  typedef logic [67:0] wr_entry_t;  // {addr, be, data}.

  logic clk_i = 1'b0;
  logic rst_i;
  logic start_i;
  tcdm_addr_t base_addr_i;
  beat_cnt_t  nb_beats_i;
  logic busy_o;
  logic done_o;
  logic [DATA_W-1:0] push_data_i;
  logic [STRB_W-1:0] push_strb_i;
  logic push_valid_i;
  logic push_ready_o;
  logic [NB_LANES-1:0] tcdm_req;
  tcdm_addr_t [NB_LANES-1:0] tcdm_add;
  lane_data_t [NB_LANES-1:0] tcdm_wdata;
  lane_be_t   [NB_LANES-1:0] tcdm_be;
  logic [NB_LANES-1:0] tcdm_gnt;

  int unsigned lcg_state = SEED;
  int unsigned proto_errs = 0;
  int unsigned data_errs = 0;
  int unsigned done_cnt = 0;
  int unsigned beat_idx;      // Beats fired in the open command.
  int unsigned cur_len;
  int unsigned exp_writes;
  int unsigned wr_mark;       // Model write count at command start.
  logic        cmd_open;
  tcdm_addr_t  cur_base;
  tcdm_addr_t  cmd_base [NB_CMDS];
  int unsigned cmd_len [NB_CMDS];
  int unsigned total_beats = 0;
  int unsigned wd_cycles;
  logic        plan_ready = 1'b0;
  wr_entry_t   exp_q [NB_LANES][$];  // Words from fired beats not yet granted.
  wr_entry_t   got_q [NB_LANES][$];  // Grants seen ahead of their beat.

  hwpe_store_top #(
    .NB_LANES(NB_LANES), .DATA_WIDTH_IN(DATA_W), .STRB_WIDTH_IN(STRB_W)
  ) DUT (
    .clk_i(clk_i), .rst_i(rst_i), .start_i(start_i), .base_addr_i(base_addr_i),
    .nb_beats_i(nb_beats_i), .busy_o(busy_o), .done_o(done_o),
    .push_data_i(push_data_i), .push_strb_i(push_strb_i), .push_valid_i(push_valid_i),
    .push_ready_o(push_ready_o), .tcdm_req_o(tcdm_req), .tcdm_add_o(tcdm_add),
    .tcdm_wdata_o(tcdm_wdata), .tcdm_be_o(tcdm_be), .tcdm_gnt_i(tcdm_gnt)
  );

  tcdm_mem_model #(
    .NB_LANES(NB_LANES), .SEED(SEED + 1), .MAX_DELAY(MAX_DELAY)
  ) i_mem (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(tcdm_req), .add_i(tcdm_add),
    .wdata_i(tcdm_wdata), .be_i(tcdm_be), .gnt_o(tcdm_gnt)
  );

  initial begin
    forever #2 clk_i = ~clk_i;  // 4 ns period.
  end

  function automatic int unsigned rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Pairs a beat word with a grant, whichever comes first waits in its queue.
  task automatic match_write(input int k, input wr_entry_t w, input bit from_grant);
    wr_entry_t other;
    if (from_grant ? (exp_q[k].size() == 0) : (got_q[k].size() == 0)) begin
      if (from_grant) got_q[k].push_back(w);
      else exp_q[k].push_back(w);
    end else begin
      other = from_grant ? exp_q[k].pop_front() : got_q[k].pop_front();
      assert (other == w) else begin
        data_errs++;
        $display("Error at %0t: lane %0d write %h, expected %h", $time, k,
                 from_grant ? w : other, from_grant ? other : w);
      end
    end
  endtask

  // Scoreboard, sampled on the rising edge.
  always @(posedge clk_i) begin : scoreboard
    tcdm_addr_t a;
    if (rst_i) begin
      cmd_open = 1'b0;
      beat_idx = 0;
      cur_len  = 0;
    end else begin
      if (start_i && !busy_o) begin
        cur_base   = base_addr_i;
        cur_len    = int'(nb_beats_i);
        beat_idx   = 0;
        exp_writes = 0;
        wr_mark    = i_mem.write_cnt;
        cmd_open   = 1'b1;
      end
      for (int k = 0; k < NB_LANES; k++) begin
        if (tcdm_req[k] && tcdm_gnt[k]) begin
          match_write(k, {tcdm_add[k], tcdm_be[k], tcdm_wdata[k]}, 1'b1);
        end
      end
      if (push_valid_i && push_ready_o) begin
        for (int k = 0; k < NB_LANES; k++) begin
          if (|push_strb_i[k*4 +: 4]) begin
            a = cur_base + tcdm_addr_t'(beat_idx * BEAT_BYTES) + tcdm_addr_t'(4 * k);
            match_write(k, {a, push_strb_i[k*4 +: 4], push_data_i[k*32 +: 32]}, 1'b0);
            exp_writes++;
          end
        end
        beat_idx++;
      end
      if (done_o) begin
        assert (cmd_open && beat_idx == cur_len) else begin
          data_errs++;
          $display("Error at %0t: done after %0d of %0d beats", $time, beat_idx, cur_len);
        end
        for (int k = 0; k < NB_LANES; k++) begin
          assert (exp_q[k].size() == 0 && got_q[k].size() == 0) else begin
            data_errs++;
            $display("Error at %0t: lane %0d has unmatched writes at done", $time, k);
          end
        end
        assert (i_mem.write_cnt - wr_mark == exp_writes) else begin
          data_errs++;
          $display("Error at %0t: %0d writes granted, expected %0d", $time,
                   i_mem.write_cnt - wr_mark, exp_writes);
        end
        cmd_open = 1'b0;
        done_cnt++;
      end
    end
  end

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !busy_o |-> (!push_ready_o && tcdm_req == '0))
    else begin
      proto_errs++;
      $display("Error at %0t: activity while idle", $time);
    end

  a_done_idle: assert property (@(posedge clk_i) disable iff (rst_i) done_o |-> !busy_o)
    else begin
      proto_errs++;
      $display("Error at %0t: done while busy", $time);
    end

  a_busy_fall: assert property (@(posedge clk_i) disable iff (rst_i) $fell(busy_o) |-> done_o)
    else begin
      proto_errs++;
      $display("Error at %0t: busy fell without done", $time);
    end

  a_beat_limit: assert property (@(posedge clk_i) disable iff (rst_i)
    (push_valid_i && push_ready_o) |-> (beat_idx < cur_len))
    else begin
      proto_errs++;
      $display("Error at %0t: beat beyond command length", $time);
    end

  for (genvar k = 0; k < NB_LANES; k++) begin : g_hold
    a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (tcdm_req[k] && !tcdm_gnt[k]) |=> (tcdm_req[k] && $stable(tcdm_add[k])
        && $stable(tcdm_wdata[k]) && $stable(tcdm_be[k])))
      else begin
        proto_errs++;
        $display("Error at %0t: lane %0d request moved", $time, k);
      end
  end

  // One beat, with an optional gap first. Ready is read mid low phase.
  task automatic send_beat();
    logic fire;
    lane_be_t be;
    while (rand_next() % 4 == 0) @(negedge clk_i);
    for (int k = 0; k < NB_LANES; k++) begin
      be = lane_be_t'(rand_next() >> 20);
      push_data_i[k*32 +: 32] = rand_next();
      push_strb_i[k*4 +: 4]   = (rand_next() % 4 == 0) ? '0 : be;  // Some silent lanes.
    end
    push_valid_i = 1'b1;
    do begin
      #1;
      fire = push_ready_o;
      @(negedge clk_i);
    end while (!fire);
    push_valid_i = 1'b0;
  endtask

  initial begin
    for (int c = 0; c < NB_CMDS; c++) begin
      cmd_len[c]  = rand_next() % (MAX_BEATS + 1);
      cmd_base[c] = tcdm_addr_t'(rand_next()) & 32'h000F_FFFC;  // Word aligned.
      total_beats += cmd_len[c];
    end
    wd_cycles  = 20 * total_beats * 8 + 500;
    plan_ready = 1'b1;
    rst_i = 1'b1;
    start_i = 1'b0;
    base_addr_i = '0;
    nb_beats_i = '0;
    push_data_i = '0;
    push_strb_i = '0;
    push_valid_i = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!busy_o && !done_o && !push_ready_o && tcdm_req == '0) else begin
      proto_errs++;
      $display("Error at %0t: outputs not quiet after reset", $time);
    end
    for (int c = 0; c < NB_CMDS; c++) begin
      start_i     = 1'b1;
      base_addr_i = cmd_base[c];
      nb_beats_i  = beat_cnt_t'(cmd_len[c]);
      @(negedge clk_i);
      start_i = 1'b0;
      for (int b = 0; b < cmd_len[c]; b++) send_beat();
      push_valid_i = 1'b1;  // Last beat offered again while draining.
      while (done_cnt != c + 1) @(negedge clk_i);
      push_valid_i = 1'b0;
    end
    repeat (5) @(negedge clk_i);
    $display("Summary: %0d protocol errors, %0d data errors", proto_errs, data_errs);
    if (proto_errs + data_errs == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the command lengths.
  initial begin
    wait (plan_ready);
    repeat (wd_cycles) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", wd_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* testbench/tcdm_mem_model.sv */
// Word memory model: grants each lane after a pseudo-random delay and logs granted writes.
`timescale 1ns/1ps

module tcdm_mem_model #(
  parameter int unsigned NB_LANES  = 4,
  parameter int unsigned SEED      = 1,
  parameter int unsigned MAX_DELAY = 3
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic [NB_LANES-1:0]                       req_i,
  input  hwpe_store_pkg::tcdm_addr_t [NB_LANES-1:0] add_i,
  input  hwpe_store_pkg::lane_data_t [NB_LANES-1:0] wdata_i,
  input  hwpe_store_pkg::lane_be_t   [NB_LANES-1:0] be_i,
  output logic [NB_LANES-1:0]                       gnt_o
);
  import hwpe_store_pkg::*;

  int unsigned lcg_state = SEED;
  int unsigned wait_q [NB_LANES];    // Cycles left before the next grant.
  lane_data_t  mem [tcdm_addr_t];    // Sparse word storage.
  int unsigned write_cnt;            // Granted writes since reset.

  // Next grant delay from the LCG, upper bits only.
  function automatic int unsigned next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return (lcg_state >> 16) % (MAX_DELAY + 1);
  endfunction

  // Grant once the lane's delay has run out.
  always_comb begin
    for (int k = 0; k < NB_LANES; k++) begin
      gnt_o[k] = req_i[k] && (wait_q[k] == 0);
    end
  end

  always @(posedge clk_i) begin : serve
    lane_data_t word;
    if (rst_i) begin
      write_cnt <= 0;
      for (int k = 0; k < NB_LANES; k++) begin
        wait_q[k] <= next_delay();
      end
    end else begin
      for (int k = 0; k < NB_LANES; k++) begin
        if (req_i[k] && gnt_o[k]) begin
          // Byte-enabled merge into the stored word.
          word = mem.exists(add_i[k]) ? mem[add_i[k]] : '0;
          for (int b = 0; b < LANE_BYTES; b++) begin
            if (be_i[k][b]) begin
              word[b*8 +: 8] = wdata_i[k][b*8 +: 8];
            end
          end
          mem[add_i[k]] = word;
          wait_q[k] <= next_delay();  // Delay for the following request.
        end else if (req_i[k]) begin
          wait_q[k] <= wait_q[k] - 1;
        end
      end
      write_cnt <= write_cnt + $countones(req_i & gnt_o);
    end
  end

endmodule

/* design/hwpe_store_top.sv */
// Store engine top: command controller, stream split and one store port per lane.
`timescale 1ns/1ps

module hwpe_store_top #(
  parameter int unsigned NB_LANES      = 4,
  parameter int unsigned DATA_WIDTH_IN = 128,
  parameter int unsigned STRB_WIDTH_IN = DATA_WIDTH_IN / 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Command and status.
  input  logic                                      start_i,
  input  hwpe_store_pkg::tcdm_addr_t                base_addr_i,
  input  hwpe_store_pkg::beat_cnt_t                 nb_beats_i,
  output logic                                      busy_o,
  output logic                                      done_o,
  // Wide input stream.
  input  logic [DATA_WIDTH_IN-1:0]                  push_data_i,
  input  logic [STRB_WIDTH_IN-1:0]                  push_strb_i,
  input  logic                                      push_valid_i,
  output logic                                      push_ready_o,
  // Memory ports, indexed by lane.
  output logic [NB_LANES-1:0]                       tcdm_req_o,
  output hwpe_store_pkg::tcdm_addr_t [NB_LANES-1:0] tcdm_add_o,
  output hwpe_store_pkg::lane_data_t [NB_LANES-1:0] tcdm_wdata_o,
  output hwpe_store_pkg::lane_be_t   [NB_LANES-1:0] tcdm_be_o,
  input  logic [NB_LANES-1:0]                       tcdm_gnt_i
);
  import hwpe_store_pkg::*;

  logic                       stream_en;   // Controller lets beats through.
  logic                       beat_fire;
  tcdm_addr_t                 beat_addr;
  logic [NB_LANES-1:0]        port_idle;
  logic [NB_LANES-1:0]        lane_valid;
  logic [NB_LANES-1:0]        lane_ready;
  lane_data_t [NB_LANES-1:0]  lane_data;
  lane_be_t   [NB_LANES-1:0]  lane_strb;

  // Decode and beat count.
  store_ctrl #(
    .NB_LANES    (NB_LANES)
  ) i_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .nb_beats_i  (nb_beats_i),
    .beat_fire_i (beat_fire),
    .port_idle_i (port_idle),
    .stream_en_o (stream_en),
    .beat_addr_o (beat_addr),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // Beat fan-out.
  hwpe_stream_split #(
    .NB_LANES      (NB_LANES),
    .DATA_WIDTH_IN (DATA_WIDTH_IN),
    .STRB_WIDTH_IN (STRB_WIDTH_IN)
  ) i_split (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .enable_i      (stream_en),
    .push_data_i   (push_data_i),
    .push_strb_i   (push_strb_i),
    .push_valid_i  (push_valid_i),
    .push_ready_o  (push_ready_o),
    .beat_fire_o   (beat_fire),
    .lane_valid_o  (lane_valid),
    .lane_data_o   (lane_data),
    .lane_strb_o   (lane_strb),
    .lane_ready_i  (lane_ready)
  );

  // One write port per lane.
  for (genvar k = 0; k < NB_LANES; k++) begin : g_port
    tcdm_store_port #(
      .LANE_IDX     (k)
    ) i_port (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .lane_valid_i (lane_valid[k]),
      .lane_data_i  (lane_data[k]),
      .lane_strb_i  (lane_strb[k]),
      .beat_addr_i  (beat_addr),
      .lane_ready_o (lane_ready[k]),
      .port_idle_o  (port_idle[k]),
      .tcdm_req_o   (tcdm_req_o[k]),
      .tcdm_add_o   (tcdm_add_o[k]),
      .tcdm_wdata_o (tcdm_wdata_o[k]),
      .tcdm_be_o    (tcdm_be_o[k]),
      .tcdm_gnt_i   (tcdm_gnt_i[k])
    );
  end

endmodule

/* design/tcdm_store_port.sv */
// Lane store port: one-entry buffer that issues a word write held until granted.
`timescale 1ns/1ps

module tcdm_store_port #(
  parameter int unsigned LANE_IDX = 0
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       lane_valid_i,
  input  hwpe_store_pkg::lane_data_t lane_data_i,
  input  hwpe_store_pkg::lane_be_t   lane_strb_i,
  input  hwpe_store_pkg::tcdm_addr_t beat_addr_i,   // Address of current beat.
  output logic                       lane_ready_o,
  output logic                       port_idle_o,   // No write pending.
  output logic                       tcdm_req_o,
  output hwpe_store_pkg::tcdm_addr_t tcdm_add_o,
  output hwpe_store_pkg::lane_data_t tcdm_wdata_o,
  output hwpe_store_pkg::lane_be_t   tcdm_be_o,
  input  logic                       tcdm_gnt_i
);
  import hwpe_store_pkg::*;

  // Byte offset of this lane inside a beat.
  localparam int unsigned LANE_OFFSET = LANE_IDX * LANE_BYTES;

  logic       full_q;    // Write pending.
  tcdm_addr_t addr_q;
  lane_data_t data_q;
  lane_be_t   be_q;
  logic       accept;    // Lane word taken this cycle.
  logic       has_bytes; // Any strobe bit set.
  logic       granted;

  assign granted      = full_q && tcdm_gnt_i;
  assign lane_ready_o = !full_q || granted;  // Back-to-back writes allowed.
  assign accept       = lane_valid_i && lane_ready_o;
  assign has_bytes    = |lane_strb_i;

  // Buffer occupancy.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= has_bytes;  // Empty strobe consumed silently.
    end else if (granted) begin
      full_q <= 1'b0;
    end
  end

  // Request fields, frozen until the next accept.
  always_ff @(posedge clk_i) begin
    if (accept && has_bytes) begin
      addr_q <= beat_addr_i + tcdm_addr_t'(LANE_OFFSET);
      data_q <= lane_data_i;
      be_q   <= lane_strb_i;
    end
  end

  assign tcdm_req_o   = full_q;
  assign tcdm_add_o   = addr_q;
  assign tcdm_wdata_o = data_q;
  assign tcdm_be_o    = be_q;
  assign port_idle_o  = !full_q;

  // Ungranted request must hold all fields.
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (tcdm_req_o && !tcdm_gnt_i) |=>
      (tcdm_req_o && $stable(tcdm_add_o) && $stable(tcdm_wdata_o) && $stable(tcdm_be_o)))
    else $error("Error at %0t: lane %0d request changed before grant", $time, LANE_IDX);

endmodule

/* hwpe_stream_split/hwpe_stream_split.sv */
// Stream split: fans one wide beat out to ordered 32-bit lanes with per-lane taken flags.
`timescale 1ns/1ps

module hwpe_stream_split #(
  parameter int unsigned NB_LANES      = 4,
  parameter int unsigned DATA_WIDTH_IN = 128,
  parameter int unsigned STRB_WIDTH_IN = DATA_WIDTH_IN / 8
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  logic                                      enable_i,      // Beats remain.
  input  logic [DATA_WIDTH_IN-1:0]                  push_data_i,
  input  logic [STRB_WIDTH_IN-1:0]                  push_strb_i,
  input  logic                                      push_valid_i,
  output logic                                      push_ready_o,
  output logic                                      beat_fire_o,   // Beat transfer.
  output logic [NB_LANES-1:0]                       lane_valid_o,
  output hwpe_store_pkg::lane_data_t [NB_LANES-1:0] lane_data_o,
  output hwpe_store_pkg::lane_be_t   [NB_LANES-1:0] lane_strb_o,
  input  logic [NB_LANES-1:0]                       lane_ready_i
);
  import hwpe_store_pkg::*;

  logic [NB_LANES-1:0] taken_q;    // Lane already holds its part of this beat.
  logic [NB_LANES-1:0] lane_fire;  // Lane handshake this cycle.
  logic [NB_LANES-1:0] lane_done;  // Taken earlier or taking now.

  for (genvar k = 0; k < NB_LANES; k++) begin : g_lane
    // Lane k gets slice k, lowest lane lowest bits.
    assign lane_data_o[k] = push_data_i[k*LANE_WIDTH +: LANE_WIDTH];
    assign lane_strb_o[k] = push_strb_i[k*LANE_BYTES +: LANE_BYTES];

    // Broadcast valid, withheld once the lane has its word.
    assign lane_valid_o[k] = push_valid_i && enable_i && !taken_q[k];
    assign lane_fire[k]    = lane_valid_o[k] && lane_ready_i[k];
  end

  assign lane_done = taken_q | lane_ready_i;

  // Ready only when every lane is covered.
  assign push_ready_o = enable_i && (&lane_done);
  assign beat_fire_o  = push_valid_i && push_ready_o;

  // Taken flags live for one beat.
  always_ff @(posedge clk_i) begin
    if (rst_i || beat_fire_o || !enable_i) begin
      taken_q <= '0;
    end else begin
      taken_q <= taken_q | lane_fire;  // Remember lanes that went early.
    end
  end

  // Enable never drops while a lane still holds part of a beat.
  a_taken_clear: assert property (@(posedge clk_i) disable iff (rst_i)
    !enable_i |-> (taken_q == '0))
    else $error("Error at %0t: taken flags set while disabled", $time);

endmodule

/* design/store_ctrl.sv */
// Store command controller: latches a command, counts beats and flags completion.
`timescale 1ns/1ps

module store_ctrl #(
  parameter int unsigned NB_LANES = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       start_i,      // One-cycle command strobe.
  input  hwpe_store_pkg::tcdm_addr_t base_addr_i,  // First beat address.
  input  hwpe_store_pkg::beat_cnt_t  nb_beats_i,   // Beats in the command.
  input  logic                       beat_fire_i,  // Input beat transferred.
  input  logic [NB_LANES-1:0]        port_idle_i,  // Store port buffers empty.
  output logic                       stream_en_o,  // Beat handshake enable.
  output hwpe_store_pkg::tcdm_addr_t beat_addr_o,  // Address of current beat.
  output logic                       busy_o,
  output logic                       done_o
);
  import hwpe_store_pkg::*;

  // Bytes covered by one full beat.
  localparam int unsigned BEAT_BYTES = NB_LANES * LANE_BYTES;

  store_state_e state_q;
  store_state_e state_d;
  beat_cnt_t    cnt_q;       // Beats fired so far.
  beat_cnt_t    cnt_nxt;
  beat_cnt_t    nb_beats_q;  // Latched length.
  tcdm_addr_t   addr_q;      // Running beat address.
  logic         done_q;
  logic         cmd_accept;
  logic         last_fire;   // Final beat of the command.
  logic         ports_idle;

  assign cmd_accept = start_i && (state_q == IDLE);  // Commands ignored while busy.
  assign cnt_nxt    = cnt_q + beat_cnt_t'(1);
  assign last_fire  = beat_fire_i && (cnt_nxt == nb_beats_q);
  assign ports_idle = &port_idle_i;                  // All writes granted.

  // Next state.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          // Empty command skips straight to completion.
          state_d = (nb_beats_i == '0) ? DRAIN : RUN;
        end
      end
      RUN: begin
        if (last_fire) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (ports_idle) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Control state.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == DRAIN) && ports_idle;  // Same edge that drops busy.
      if (cmd_accept) begin
        cnt_q <= '0;
      end else if (beat_fire_i) begin
        cnt_q <= cnt_nxt;
      end
    end
  end

  // Command payload, loaded on accept.
  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      nb_beats_q <= nb_beats_i;
      addr_q     <= base_addr_i;
    end else if (beat_fire_i) begin
      addr_q <= addr_q + tcdm_addr_t'(BEAT_BYTES);  // Step a full beat.
    end
  end

  assign stream_en_o = (state_q == RUN);
  assign beat_addr_o = addr_q;
  assign busy_o      = (state_q != IDLE);
  assign done_o      = done_q;

  // Split must only fire while the controller runs.
  a_fire_in_run: assert property (@(posedge clk_i) disable iff (rst_i)
    beat_fire_i |-> (state_q == RUN))
    else $error("Error at %0t: beat fired outside RUN", $time);

  // Completion is a single pulse.
  a_done_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |=> !done_o)
    else $error("Error at %0t: done held for two cycles", $time);

endmodule

/* common/hwpe_store_pkg.sv */
// Store engine shared definitions: memory port widths, lane types and controller states.
package hwpe_store_pkg;

  // Memory port geometry.
  localparam int unsigned ADDR_WIDTH = 32;              // Byte address.
  localparam int unsigned LANE_WIDTH = 32;              // One memory word per lane.
  localparam int unsigned LANE_BYTES = LANE_WIDTH / 8;  // Sets the lane address step.

  // Command length width.
  localparam int unsigned BEAT_CNT_WIDTH = 16;

  // Byte address on a memory port.
  typedef logic [ADDR_WIDTH-1:0] tcdm_addr_t;

  // Lane word and its byte enables.
  typedef logic [LANE_WIDTH-1:0] lane_data_t;
  typedef logic [LANE_BYTES-1:0] lane_be_t;

  // Beat counter, also the command length.
  typedef logic [BEAT_CNT_WIDTH-1:0] beat_cnt_t;

  // Controller states.
  // IDLE waits for a command, RUN moves beats, DRAIN waits for the ports to empty.
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } store_state_e;

endpackage
